// ==== common/rename_types_pkg.sv ====
`default_nettype none

package rename_types_pkg;

    localparam int ARCH_REGS = 32;
    localparam int PHYS_REGS = 64;
    localparam int FREE_SIZE = PHYS_REGS - ARCH_REGS;

    localparam int ARN_W      = $clog2(ARCH_REGS);
    localparam int PRN_W      = $clog2(PHYS_REGS);
    localparam int FREE_PTR_W = $clog2(FREE_SIZE);      // 5 bits
    localparam int FREE_CNT_W = $clog2(FREE_SIZE + 1);  // 6 bits, holds FREE_SIZE itself

    typedef logic [ARN_W-1:0] arn_t;
    typedef logic [PRN_W-1:0] prn_t;

    typedef struct packed {
        logic valid;
        prn_t prn;
    } free_list_packet_t;

    // Whole list state, loaded in one go on squash
    typedef struct packed {
        prn_t [FREE_SIZE-1:0]  entries;
        logic [FREE_PTR_W-1:0] head;
        logic [FREE_PTR_W-1:0] tail;
        logic [FREE_CNT_W-1:0] count;
    } free_list_state_t;

    typedef prn_t [ARCH_REGS-1:0] map_table_t;

endpackage

`default_nettype wire

// ==== common/rename_ports_pkg.sv ====
`default_nettype none

package rename_ports_pkg;

    import rename_types_pkg::*;

    typedef struct packed {
        logic valid;
        arn_t dest;
        arn_t src1;
        arn_t src2;
    } rename_req_t;

    typedef struct packed {
        logic valid;
        prn_t dest;
        prn_t src1;
        prn_t src2;
    } rename_resp_t;

    // One retiring instruction and the prn it commits
    typedef struct packed {
        logic valid;
        arn_t arn;
        prn_t prn;
    } retire_t;

endpackage

`default_nettype wire

// ==== rename/free_list.sv ====
`default_nettype none

module free_list
    import rename_types_pkg::*;
#(
    parameter int WIDTH = 2
) (
    input  logic                          clock,
    input  logic                          reset,
    input  free_list_packet_t [WIDTH-1:0] push_packet,
    input  logic              [WIDTH-1:0] pop_en,
    input  logic                          restore,
    input  free_list_state_t              restore_state,
    output free_list_packet_t [WIDTH-1:0] pop_packet,
    output logic         [FREE_CNT_W-1:0] count,
    output free_list_state_t              next_state
);

    free_list_state_t              state;
    free_list_packet_t [WIDTH-1:0] next_pop;

    // Circular pointer advance
    function automatic logic [FREE_PTR_W-1:0] ptr_inc(input logic [FREE_PTR_W-1:0] ptr);
        if (ptr == FREE_PTR_W'(FREE_SIZE - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    always_comb begin
        next_state = state;
        next_pop   = '0;

        if (restore) begin
            next_state = restore_state;  // no pops, pushes dropped
        end else begin
            // Pops first, in lane order
            for (int i = 0; i < WIDTH; i++) begin
                if (pop_en[i] && next_state.count != '0) begin
                    next_pop[i].valid = 1'b1;
                    next_pop[i].prn   = next_state.entries[next_state.head];
                    next_state.head   = ptr_inc(next_state.head);
                    next_state.count  = next_state.count - 1'b1;
                end
            end

            // Then pushes at the tail
            for (int i = 0; i < WIDTH; i++) begin
                if (push_packet[i].valid && next_state.count < FREE_SIZE) begin
                    next_state.entries[next_state.tail] = push_packet[i].prn;
                    next_state.tail  = ptr_inc(next_state.tail);
                    next_state.count = next_state.count + 1'b1;
                end
            end
        end
    end

    assign count = state.count;

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < FREE_SIZE; i++) begin
                state.entries[i] <= prn_t'(ARCH_REGS + i);  // upper prns free at start
            end
            state.head  <= '0;
            state.tail  <= '0;
            state.count <= FREE_CNT_W'(FREE_SIZE);
            pop_packet  <= '0;
        end else begin
            state      <= next_state;
            pop_packet <= next_pop;
        end
    end

endmodule

`default_nettype wire

// ==== rename/rat.sv ====
`default_nettype none

module rat
    import rename_types_pkg::*;
    import rename_ports_pkg::*;
#(
    parameter int WIDTH = 2
) (
    input  logic                          clock,
    input  logic                          reset,
    input  rename_req_t       [WIDTH-1:0] req,
    input  free_list_packet_t [WIDTH-1:0] new_prn,
    input  logic                          squash,
    input  map_table_t                    restore_map,
    output rename_resp_t      [WIDTH-1:0] resp
);

    map_table_t               map;
    map_table_t               next_map;
    rename_resp_t [WIDTH-1:0] next_resp;
    logic         [WIDTH-1:0] live;

    always_comb begin
        next_map  = map;
        next_resp = '0;

        for (int i = 0; i < WIDTH; i++) begin
            live[i] = req[i].valid && new_prn[i].valid;
        end

        for (int i = 0; i < WIDTH; i++) begin
            next_resp[i].valid = live[i];
            next_resp[i].dest  = new_prn[i].prn;
            next_resp[i].src1  = map[req[i].src1];
            next_resp[i].src2  = map[req[i].src2];
            // Youngest older writer wins
            for (int j = 0; j < i; j++) begin
                if (live[j] && req[j].dest == req[i].src1) begin
                    next_resp[i].src1 = new_prn[j].prn;
                end
                if (live[j] && req[j].dest == req[i].src2) begin
                    next_resp[i].src2 = new_prn[j].prn;
                end
            end
        end

        for (int i = 0; i < WIDTH; i++) begin
            if (live[i]) begin
                next_map[req[i].dest] = new_prn[i].prn;  // last lane wins
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < ARCH_REGS; i++) begin
                map[i] <= prn_t'(i);
            end
            resp <= '0;
        end else if (squash) begin
            map  <= restore_map;
            resp <= '0;
        end else begin
            map  <= next_map;
            resp <= next_resp;
        end
    end

endmodule

`default_nettype wire

// ==== rename/rrat.sv ====
`default_nettype none

module rrat
    import rename_types_pkg::*;
    import rename_ports_pkg::*;
#(
    parameter int WIDTH = 2
) (
    input  logic                          clock,
    input  logic                          reset,
    input  retire_t           [WIDTH-1:0] retire,
    output free_list_packet_t [WIDTH-1:0] told,
    output map_table_t                    next_map
);

    map_table_t map;

    // Walking the lanes in order gives forwarding from older lanes for free
    always_comb begin
        next_map = map;
        told     = '0;
        for (int i = 0; i < WIDTH; i++) begin
            if (retire[i].valid) begin
                told[i].valid             = 1'b1;
                told[i].prn               = next_map[retire[i].arn];
                next_map[retire[i].arn]   = retire[i].prn;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < ARCH_REGS; i++) begin
                map[i] <= prn_t'(i);  // identity
            end
        end else begin
            map <= next_map;
        end
    end

endmodule

`default_nettype wire

// ==== rename/rename_unit.sv ====
`default_nettype none

module rename_unit
    import rename_types_pkg::*;
    import rename_ports_pkg::*;
#(
    parameter int WIDTH = 2
) (
    input  logic                     clock,
    input  logic                     reset,
    input  rename_req_t  [WIDTH-1:0] rename_req,
    input  retire_t      [WIDTH-1:0] retire,
    input  logic                     squash,
    output rename_resp_t [WIDTH-1:0] rename_resp,
    output logic                     rename_ready
);

    rename_req_t       [WIDTH-1:0] staged_req;
    free_list_packet_t [WIDTH-1:0] spec_pop;
    free_list_packet_t [WIDTH-1:0] told;
    logic              [WIDTH-1:0] spec_pop_en;
    logic              [WIDTH-1:0] retire_en;
    logic         [FREE_CNT_W-1:0] spec_count;
    free_list_state_t              arch_state;
    map_table_t                    arch_map;

    assign rename_ready = spec_count >= FREE_CNT_W'(WIDTH);  // room for a full group

    always_comb begin
        for (int i = 0; i < WIDTH; i++) begin
            spec_pop_en[i] = rename_req[i].valid && rename_ready && !squash;
            retire_en[i]   = retire[i].valid;
        end
    end

    // Request stage, lines up with the registered pops
    always_ff @(posedge clock) begin
        if (reset || squash) begin
            staged_req <= '0;
        end else begin
            for (int i = 0; i < WIDTH; i++) begin
                staged_req[i]       <= rename_req[i];
                staged_req[i].valid <= spec_pop_en[i];
            end
        end
    end

    free_list #(.WIDTH(WIDTH)) spec_free_list (
        .clock         (clock),
        .reset         (reset),
        .push_packet   (told),
        .pop_en        (spec_pop_en),
        .restore       (squash),
        .restore_state (arch_state),
        .pop_packet    (spec_pop),
        .count         (spec_count),
        .next_state    ()
    );

    // Popped once per retire, mirrors committed allocation
    free_list #(.WIDTH(WIDTH)) arch_free_list (
        .clock         (clock),
        .reset         (reset),
        .push_packet   (told),
        .pop_en        (retire_en),
        .restore       (1'b0),
        .restore_state ('0),
        .pop_packet    (),
        .count         (),
        .next_state    (arch_state)
    );

    rat #(.WIDTH(WIDTH)) i_rat (
        .clock       (clock),
        .reset       (reset),
        .req         (staged_req),
        .new_prn     (spec_pop),
        .squash      (squash),
        .restore_map (arch_map),
        .resp        (rename_resp)
    );

    rrat #(.WIDTH(WIDTH)) i_rrat (
        .clock    (clock),
        .reset    (reset),
        .retire   (retire),
        .told     (told),
        .next_map (arch_map)
    );

endmodule

`default_nettype wire

// ==== testbench/rename_tb.sv ====
`default_nettype none

module rename_tb
    import rename_types_pkg::*;
    import rename_ports_pkg::*;
();

    localparam int WIDTH          = 2;
    localparam int PLANNED_CYCLES = 400;

    logic                     clock;
    logic                     reset;
    rename_req_t  [WIDTH-1:0] rename_req;
    retire_t      [WIDTH-1:0] retire;
    logic                     squash;
    rename_resp_t [WIDTH-1:0] rename_resp;
    logic                     rename_ready;

    // Reference model state
    prn_t                     model_rat  [ARCH_REGS];
    prn_t                     model_rrat [ARCH_REGS];
    prn_t                     spec_q[$];
    prn_t                     arch_q[$];
    prn_t                     told_log[$];
    prn_t                     seen[$];      // DUT dests in output order
    retire_t                  inflight[$];  // responded, not yet retired
    rename_req_t  [WIDTH-1:0] staged;
    prn_t                     staged_prn [WIDTH];
    rename_resp_t [WIDTH-1:0] exp_resp;

    int passed      = 0;
    int failed      = 0;
    int test_failed = 0;

    rename_unit #(.WIDTH(WIDTH)) i_rename_unit (.*);

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    initial begin
        #(PLANNED_CYCLES * 40 * 10);
        $display("timeout: run did not finish within %0d cycles", PLANNED_CYCLES * 40);
        $display("TESTBENCH FAILED");
        $finish;
    end

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        assert (got === expected) begin
            passed++;
        end else begin
            failed++;
            $display("error %0t: %s got %0d expected %0d", $time, what, got, expected);
        end
    endtask

    function automatic bit model_ready();
        return spec_q.size() >= WIDTH;
    endfunction

    // Effect of the coming rising edge on the model
    task automatic model_edge();
        prn_t             told [WIDTH];
        logic [WIDTH-1:0] told_v;
        logic             ready;
        retire_t          entry;
        ready  = model_ready();
        told_v = '0;
        for (int i = 0; i < WIDTH; i++) begin
            if (retire[i].valid) begin
                told_v[i]                   = 1'b1;
                told[i]                     = model_rrat[retire[i].arn];
                model_rrat[retire[i].arn]   = retire[i].prn;
                void'(arch_q.pop_front());
                told_log.push_back(told[i]);
            end
        end
        for (int i = 0; i < WIDTH; i++) begin
            if (told_v[i]) begin
                arch_q.push_back(told[i]);
            end
        end
        exp_resp = '0;
        if (squash) begin
            model_rat = model_rrat;
            spec_q    = arch_q;
            staged    = '0;
            inflight.delete();
        end else begin
            // Lanes in order, each sees older lanes' writes
            for (int i = 0; i < WIDTH; i++) begin
                if (staged[i].valid) begin
                    exp_resp[i].valid = 1'b1;
                    exp_resp[i].dest  = staged_prn[i];
                    exp_resp[i].src1  = model_rat[staged[i].src1];
                    exp_resp[i].src2  = model_rat[staged[i].src2];
                    model_rat[staged[i].dest] = staged_prn[i];
                    entry.valid = 1'b1;
                    entry.arn   = staged[i].dest;
                    entry.prn   = staged_prn[i];
                    inflight.push_back(entry);
                end
            end
            staged = '0;
            for (int i = 0; i < WIDTH; i++) begin
                if (rename_req[i].valid && ready) begin
                    staged[i]     = rename_req[i];
                    staged_prn[i] = spec_q.pop_front();
                end
            end
            for (int i = 0; i < WIDTH; i++) begin
                if (told_v[i]) begin
                    spec_q.push_back(told[i]);
                end
            end
        end
    endtask

    task automatic check_outputs();
        for (int i = 0; i < WIDTH; i++) begin
            check_value($sformatf("lane %0d valid", i), rename_resp[i].valid, exp_resp[i].valid);
            if (exp_resp[i].valid) begin
                check_value($sformatf("lane %0d dest", i), rename_resp[i].dest, exp_resp[i].dest);
                check_value($sformatf("lane %0d src1", i), rename_resp[i].src1, exp_resp[i].src1);
                check_value($sformatf("lane %0d src2", i), rename_resp[i].src2, exp_resp[i].src2);
            end
            if (rename_resp[i].valid) begin
                seen.push_back(rename_resp[i].dest);
            end
        end
        check_value("rename_ready", rename_ready, model_ready());
    endtask

    task automatic clear_inputs();
        rename_req = '0;
        retire     = '0;
        squash     = 1'b0;
    endtask

    // Inputs are set at a falling edge, checked at the next one
    task automatic tick();
        model_edge();
        @(negedge clock);
        check_outputs();
        clear_inputs();
    endtask

    task automatic drive_rename(input int lane, input int dest, input int src1, input int src2);
        rename_req[lane].valid = 1'b1;
        rename_req[lane].dest  = arn_t'(dest);
        rename_req[lane].src1  = arn_t'(src1);
        rename_req[lane].src2  = arn_t'(src2);
    endtask

    task automatic drive_group(input int base);
        for (int i = 0; i < WIDTH; i++) begin
            drive_rename(i, (base + i) % ARCH_REGS, (base + i + 7) % ARCH_REGS,
                         (base + 3) % ARCH_REGS);
        end
    endtask

    task automatic drive_retire(input int lanes);
        for (int i = 0; i < lanes && inflight.size() > 0; i++) begin
            retire[i] = inflight.pop_front();
        end
    endtask

    task automatic retire_all();
        repeat (2) tick();
        while (inflight.size() > 0) begin
            drive_retire(WIDTH);
            tick();
        end
    endtask

    task automatic end_test(input string name);
        $display("%s: %0d checks failed", name, failed - test_failed);
        test_failed = failed;
    endtask

    initial begin
        int   allocated;
        prn_t expected [WIDTH];
        void'($urandom(32'had3e_ffbc));
        clear_inputs();
        reset = 1'b1;
        for (int i = 0; i < ARCH_REGS; i++) begin
            model_rat[i]  = prn_t'(i);
            model_rrat[i] = prn_t'(i);
        end
        for (int i = 0; i < FREE_SIZE; i++) begin
            spec_q.push_back(prn_t'(ARCH_REGS + i));
            arch_q.push_back(prn_t'(ARCH_REGS + i));
        end
        staged   = '0;
        exp_resp = '0;
        repeat (5) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        check_outputs();

        // Sources 16..31 are never written here
        for (int g = 0; g < 4; g++) begin
            drive_rename(0, 1 + 2 * g, 16 + 4 * g, 17 + 4 * g);
            drive_rename(1, 2 + 2 * g, 18 + 4 * g, 19 + 4 * g);
            tick();
        end
        repeat (2) tick();
        for (int k = 0; k < 8; k++) begin
            check_value("first allocations", seen[k], ARCH_REGS + k);
        end
        end_test("reset allocation");

        drive_rename(0, 10, 1, 2);
        drive_rename(1, 11, 10, 10);
        tick();
        drive_rename(0, 12, 3, 4);
        drive_rename(1, 12, 12, 5);  // same dest as lane 0
        tick();
        drive_rename(0, 13, 12, 11);
        repeat (3) tick();
        end_test("same group dependency");

        retire_all();
        allocated = 0;
        while (rename_ready && allocated < 2 * FREE_SIZE) begin
            drive_group(allocated);
            allocated += WIDTH;
            tick();
        end
        check_value("allocations until not ready", allocated, FREE_SIZE);
        repeat (2) tick();
        told_log.delete();
        drive_retire(WIDTH);
        tick();
        check_value("ready after retire", rename_ready, 1);
        seen.delete();
        drive_group(3);
        repeat (2) tick();
        for (int i = 0; i < WIDTH; i++) begin
            check_value("reissued told", seen[i], told_log[i]);
        end
        end_test("exhaustion and refill");

        retire_all();
        for (int g = 0; g < 3; g++) begin
            drive_group(4 * g);
            tick();
        end
        repeat (2) tick();
        drive_retire(2);
        tick();
        drive_retire(1);
        tick();
        drive_group(20);  // staged when the squash hits
        tick();
        squash = 1'b1;
        drive_group(24);
        tick();
        check_value("response after squash", rename_resp[0].valid | rename_resp[1].valid, 0);
        for (int i = 0; i < WIDTH; i++) begin
            expected[i] = arch_q[i];
        end
        seen.delete();
        // Sources renamed but never retired, and one from the dropped group
        drive_rename(0, 2, 5, 8);
        drive_rename(1, 3, 9, 20);
        repeat (2) tick();
        for (int i = 0; i < WIDTH; i++) begin
            check_value("allocation after squash", seen[i], expected[i]);
        end
        end_test("squash restore");

        for (int c = 0; c < 300; c++) begin
            if ($urandom % 100 < 4) begin
                squash = 1'b1;
            end else begin
                for (int i = 0; i < WIDTH; i++) begin
                    if (model_ready() && $urandom % 4 != 0) begin
                        drive_rename(i, $urandom % ARCH_REGS, $urandom % ARCH_REGS,
                                     $urandom % ARCH_REGS);
                    end
                end
                drive_retire($urandom % (WIDTH + 1));
            end
            tick();
        end
        repeat (2) tick();
        end_test("random mix");

        $display("checks passed %0d, failed %0d", passed, failed);
        if (failed == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
common/rename_types_pkg.sv
common/rename_ports_pkg.sv
rename/free_list.sv
rename/rat.sv
rename/rrat.sv
rename/rename_unit.sv
testbench/rename_tb.sv

// ==== Bender.yml ====
package:
  name: rename_unit

sources:
  - common/rename_types_pkg.sv
  - common/rename_ports_pkg.sv
  - rename/free_list.sv
  - rename/rat.sv
  - rename/rrat.sv
  - rename/rename_unit.sv
  - target: test
    files:
      - testbench/rename_tb.sv
